// File: common/obj_consts.svh
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// table and line sizes
`define OBJ_NUM_SPRITES     256
`define OBJ_NUM_PRI         16
`define OBJ_QUEUE_DEPTH     256
`define OBJ_LINE_W          320     // x from here up is clipped
`define OBJ_POS_MASK_BITS   9       // positions wrap at 512

// tile slice geometry, 8x8 tiles at 4bpp
`define OBJ_TILE_ROW_BYTES  4
`define OBJ_TILE_BYTES      32

// word 0
`define OBJ_W0_ACTIVE       15
`define OBJ_W0_XFLIP        12
`define OBJ_W0_PRI          11:8
`define OBJ_W0_PAL          7:2
`define OBJ_W0_BANK         1:0     // upper two bank bits

// word 1
`define OBJ_W1_BANK         15      // lowest bank bit
`define OBJ_W1_TILE         14:0

// words 2 and 3 share the position / size layout
`define OBJ_POS             15:7
`define OBJ_SIZE            3:0

`endif

// File: common/obj_pkg.sv
`default_nettype none

`include "obj_consts.svh"

package obj_pkg;

    typedef logic [12:0] spr_addr_t;    // word address into sprite RAM
    typedef logic [15:0] spr_word_t;
    typedef logic [7:0]  spr_index_t;
    typedef logic [3:0]  pri_t;
    typedef logic [3:0]  size_t;        // tiles minus one
    typedef logic [`OBJ_POS_MASK_BITS-1:0] pos_t;
    typedef logic [`OBJ_POS_MASK_BITS-1:0] lbuf_addr_t;

    // queue address is {priority, slot}
    typedef logic [11:0] q_addr_t;
    typedef logic [$clog2(`OBJ_QUEUE_DEPTH):0] q_count_t;

    typedef struct packed {
        q_count_t [`OBJ_NUM_PRI-1:0] cnt;
    } pri_counts_t;

    // only the low 9 bits of each field take part
    typedef struct packed {
        logic [12:0] scroll_x;
        logic [12:0] scroll_y;
        logic [12:0] xoffs;
        logic [12:0] yoffs;
    } obj_scroll_t;

    typedef struct packed {
        logic [14:0] tile_num;
        logic [15:0] tile_offs;     // byte offset inside the tile data
        logic [2:0]  bank;
    } gfx_req_t;

    typedef struct packed {
        pri_t       pri;
        logic [5:0] palette;
        logic [3:0] color;          // 0 is transparent
    } obj_pixel_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_rd0,
        scan_rd3,
        scan_hit
    } scan_state_t;

    typedef enum logic [3:0] {
        rnd_idle,
        rnd_pri,
        rnd_adv,
        rnd_qrd,
        rnd_idx,
        rnd_attr,
        rnd_req,
        rnd_wait,
        rnd_draw
    } render_state_t;

endpackage

`default_nettype wire

// File: hw/scan/obj_line_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_line_scanner (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  wire                         line_start_i,
    input  wire obj_pkg::pos_t          vrender_i,
    input  wire obj_pkg::obj_scroll_t   scroll_i,
    output obj_pkg::spr_addr_t          spr_a_addr_o,
    input  wire obj_pkg::spr_word_t     spr_a_data_i,
    output logic                        q_we_o,
    output obj_pkg::q_addr_t            q_waddr_o,
    output obj_pkg::spr_index_t         q_wdata_o,
    output logic                        scan_done_o,
    output obj_pkg::pri_counts_t        pri_counts_o
);
    import obj_pkg::*;

    scan_state_t state;
    spr_index_t  spr;
    pri_t        pri;
    pos_t        line_v;
    pos_t        ypos;
    pos_t        dy;
    logic [7:0]  height;
    logic        hit;
    logic        last;
    logic        advance;

    // w0 is requested first, w3 while w0 comes back
    assign spr_a_addr_o = (state == scan_rd3) ? spr_addr_t'({spr, 2'd3})
                                              : spr_addr_t'({spr, 2'd0});

    // w3 is on the data port in scan_hit
    assign ypos   = spr_a_data_i[`OBJ_POS] + pos_t'(scroll_i.scroll_y)
                  + pos_t'(scroll_i.yoffs);
    assign dy     = line_v - ypos;                      // wraps mod 512
    assign height = {({1'b0, spr_a_data_i[`OBJ_SIZE]} + 5'd1), 3'b000};
    assign hit    = dy < {1'b0, height};

    assign last    = (spr == spr_index_t'(`OBJ_NUM_SPRITES - 1));
    assign advance = (state == scan_hit) ||
                     (state == scan_rd3 && !spr_a_data_i[`OBJ_W0_ACTIVE]);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state        <= scan_idle;
            spr          <= '0;
            q_we_o       <= 1'b0;
            scan_done_o  <= 1'b0;
            pri_counts_o <= '0;
        end else begin
            q_we_o      <= 1'b0;
            scan_done_o <= 1'b0;
            case (state)
                scan_idle: begin
                    if (line_start_i) begin
                        spr          <= '0;
                        pri_counts_o <= '0;
                        line_v       <= vrender_i;
                        state        <= scan_rd0;
                    end
                end
                scan_rd0: state <= scan_rd3;
                scan_rd3: begin
                    if (spr_a_data_i[`OBJ_W0_ACTIVE]) begin
                        pri   <= spr_a_data_i[`OBJ_W0_PRI];
                        state <= scan_hit;
                    end
                end
                scan_hit: begin
                    if (hit) begin
                        q_we_o    <= 1'b1;
                        q_waddr_o <= {pri, spr_index_t'(pri_counts_o.cnt[pri])};
                        q_wdata_o <= spr;
                        pri_counts_o.cnt[pri] <= pri_counts_o.cnt[pri] + 1'b1;
                    end
                end
                default: state <= scan_idle;
            endcase

            if (advance) begin
                if (last) begin
                    scan_done_o <= 1'b1;    // counts hold until next line start
                    state       <= scan_idle;
                end else begin
                    spr   <= spr + 1'b1;
                    state <= scan_rd0;
                end
            end
        end
    end

    a_scan_in_time: assert property (@(posedge CLK96) disable iff (RESET96)
        line_start_i |-> state == scan_idle);

endmodule

`default_nettype wire

// File: hw/scan/obj_pri_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

// 4096x8, one 256-entry queue per priority, addressed as {priority, slot}
module obj_pri_queue (
    input  wire                         CLK96,
    input  wire                         we_i,
    input  wire obj_pkg::q_addr_t       waddr_i,
    input  wire obj_pkg::spr_index_t    wdata_i,
    input  wire obj_pkg::q_addr_t       raddr_i,
    output obj_pkg::spr_index_t         rdata_o
);
    import obj_pkg::*;

    spr_index_t mem [`OBJ_NUM_PRI * `OBJ_QUEUE_DEPTH];

    always_ff @(posedge CLK96) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];    // one cycle read latency
    end

endmodule

`default_nettype wire

// File: hw/render/obj_tile_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_tile_renderer (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  wire                         scan_done_i,
    input  wire obj_pkg::pri_counts_t   pri_counts_i,
    input  wire obj_pkg::pos_t          vrender_i,
    input  wire obj_pkg::obj_scroll_t   scroll_i,
    output obj_pkg::q_addr_t            q_raddr_o,
    input  wire obj_pkg::spr_index_t    q_rdata_i,
    output obj_pkg::spr_addr_t          spr_b_addr_o,
    input  wire obj_pkg::spr_word_t     spr_b_data_i,
    output logic                        gfx_cs_o,
    output obj_pkg::gfx_req_t           gfx_req_o,
    input  wire                         gfx_ok_i,
    input  wire [31:0]                  gfx_data_i,
    output logic                        lb_we_o,
    output obj_pkg::lbuf_addr_t         lb_addr_o,
    output obj_pkg::obj_pixel_t         lb_data_o,
    output logic                        busy_o
);
    import obj_pkg::*;

    render_state_t   state;
    pri_t            pri;
    spr_index_t      slot;
    spr_index_t      sidx;
    logic [2:0]      wcnt;      // attribute word fetch, one behind the address
    spr_word_t [3:0] attr;
    pos_t            line_v;
    size_t           col;
    logic [2:0]      k;
    logic [31:0]     slice;
    q_count_t        cnt;
    logic            xflip;
    size_t           xsize;
    pos_t            xpos;
    pos_t            line;
    logic [15:0]     offs;
    pos_t            px;
    logic [3:0]      pix_col;

    assign cnt          = pri_counts_i.cnt[pri];
    assign q_raddr_o    = {pri, slot};
    assign spr_b_addr_o = spr_addr_t'({sidx, wcnt[1:0]});
    assign busy_o       = (state != rnd_idle);

    assign xflip = attr[0][`OBJ_W0_XFLIP];
    assign xsize = attr[2][`OBJ_SIZE];
    assign xpos  = attr[2][`OBJ_POS] + pos_t'(scroll_i.scroll_x) + pos_t'(scroll_i.xoffs);
    assign line  = line_v - (attr[3][`OBJ_POS] + pos_t'(scroll_i.scroll_y)
                 + pos_t'(scroll_i.yoffs));

    // tile rows are xsize+1 tiles wide, 4 bytes per pixel row
    assign offs = 16'((line[8:3] * ({1'b0, xsize} + 5'd1) + col) * `OBJ_TILE_BYTES
                + line[2:0] * `OBJ_TILE_ROW_BYTES);

    assign pix_col = slice[{k, 2'b00} +: 4];
    assign px = xflip ? pos_t'(xpos + {xsize - col, 3'b000} + (3'd7 - k))
                      : pos_t'(xpos + {col, 3'b000} + k);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state    <= rnd_idle;
            pri      <= '0;
            slot     <= '0;
            wcnt     <= '0;
            col      <= '0;
            k        <= '0;
            gfx_cs_o <= 1'b0;
            lb_we_o  <= 1'b0;
        end else begin
            lb_we_o <= 1'b0;
            case (state)
                rnd_idle: begin
                    if (scan_done_i) begin
                        pri    <= '0;
                        line_v <= vrender_i;
                        state  <= rnd_pri;
                    end
                end
                rnd_pri: begin
                    slot  <= '0;
                    state <= (cnt != '0) ? rnd_qrd : rnd_adv;   // skip empty queues
                end
                rnd_adv: begin
                    if (pri == pri_t'(`OBJ_NUM_PRI - 1)) begin
                        state <= rnd_idle;
                    end else begin
                        pri   <= pri + 1'b1;
                        state <= rnd_pri;
                    end
                end
                rnd_qrd: state <= rnd_idx;
                rnd_idx: begin
                    sidx  <= q_rdata_i;
                    wcnt  <= '0;
                    state <= rnd_attr;
                end
                rnd_attr: begin
                    wcnt <= wcnt + 1'b1;
                    if (wcnt != 3'd0) begin
                        attr[2'(wcnt - 3'd1)] <= spr_b_data_i;
                    end
                    if (wcnt == 3'd4) begin
                        col   <= '0;
                        state <= rnd_req;
                    end
                end
                rnd_req: begin
                    gfx_cs_o  <= 1'b1;
                    gfx_req_o <= '{tile_num:  attr[1][`OBJ_W1_TILE],
                                   tile_offs: offs,
                                   bank:      {attr[0][`OBJ_W0_BANK], attr[1][`OBJ_W1_BANK]}};
                    state     <= rnd_wait;
                end
                rnd_wait: begin
                    if (gfx_ok_i) begin         // data valid with ok
                        gfx_cs_o <= 1'b0;
                        slice    <= gfx_data_i;
                        k        <= '0;
                        state    <= rnd_draw;
                    end
                end
                rnd_draw: begin
                    lb_we_o   <= (pix_col != 4'd0) && (px < `OBJ_LINE_W);
                    lb_addr_o <= px;
                    lb_data_o <= '{pri:     attr[0][`OBJ_W0_PRI],
                                   palette: attr[0][`OBJ_W0_PAL],
                                   color:   pix_col};
                    k <= k + 1'b1;
                    if (k == 3'd7) begin
                        if (col != xsize) begin
                            col   <= col + 1'b1;
                            state <= rnd_req;
                        end else if ({1'b0, slot} + 9'd1 < cnt) begin
                            slot  <= slot + 1'b1;
                            state <= rnd_qrd;
                        end else begin
                            state <= rnd_adv;
                        end
                    end
                end
                default: state <= rnd_idle;
            endcase
        end
    end

    // held request, only ok may end it
    a_gfx_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_o && !gfx_ok_i |=> gfx_cs_o && $stable(gfx_req_o));

endmodule

`default_nettype wire

// File: hw/render/obj_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_line_buffer (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  wire                         hblank_i,
    input  wire                         vblank_i,
    input  wire obj_pkg::pos_t          vrender_i,
    input  wire                         pixel_cen_i,
    input  wire                         active_i,
    input  wire obj_pkg::pos_t          h_i,
    input  wire                         we_i,
    input  wire obj_pkg::lbuf_addr_t    addr_i,
    input  wire obj_pkg::obj_pixel_t    data_i,
    output logic                        line_start_o,
    output obj_pkg::obj_pixel_t         obj_pixel_o
);
    import obj_pkg::*;

    localparam int DEPTH = 2 ** `OBJ_POS_MASK_BITS;

    obj_pixel_t mem [2][DEPTH];
    logic       hb_d;
    logic       bank;           // bank taking renderer writes
    logic       clr_busy;
    lbuf_addr_t clr_addr;
    logic       rd_en;
    logic [1:0] bank_we;
    lbuf_addr_t bank_addr [2];
    obj_pixel_t bank_data [2];

    assign rd_en = pixel_cen_i & active_i;

    // write port per bank: clear sweep, renderer, or read-and-clear
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (clr_busy) begin
                bank_we[b]   = 1'b1;
                bank_addr[b] = clr_addr;
                bank_data[b] = '0;
            end else if (1'(b) == bank) begin
                bank_we[b]   = we_i;
                bank_addr[b] = addr_i;
                bank_data[b] = data_i;
            end else begin
                bank_we[b]   = rd_en;
                bank_addr[b] = h_i;
                bank_data[b] = '0;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        for (int b = 0; b < 2; b++) begin
            if (bank_we[b]) begin
                mem[b][bank_addr[b]] <= bank_data[b];
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hb_d         <= 1'b0;
            line_start_o <= 1'b0;
            bank         <= 1'b0;
            clr_busy     <= 1'b1;
            clr_addr     <= '0;
            obj_pixel_o  <= '0;
        end else begin
            hb_d <= hblank_i;
            // hblank falling edge, also in vblank on line 0
            line_start_o <= hb_d && !hblank_i && (!vblank_i || vrender_i == '0);
            if (line_start_o) begin
                bank <= ~bank;
            end
            if (clr_busy) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == '1) begin
                    clr_busy <= 1'b0;
                end
            end
            if (rd_en) begin
                obj_pixel_o <= clr_busy ? '0 : mem[~bank][h_i];
            end
        end
    end

    // renderer clips before it writes
    a_addr_in_line: assert property (@(posedge CLK96) disable iff (RESET96)
        we_i |-> addr_i < `OBJ_LINE_W);

endmodule

`default_nettype wire

// File: hw/obj_engine.sv
`timescale 1ns/1ps
`default_nettype none

module obj_engine (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  wire                         hblank_i,
    input  wire                         vblank_i,
    input  wire                         pixel_cen_i,
    input  wire                         active_i,
    input  wire obj_pkg::pos_t          vrender_i,
    input  wire obj_pkg::pos_t          h_i,
    input  wire obj_pkg::obj_scroll_t   scroll_i,
    output obj_pkg::spr_addr_t          spr_a_addr_o,
    input  wire obj_pkg::spr_word_t     spr_a_data_i,
    output obj_pkg::spr_addr_t          spr_b_addr_o,
    input  wire obj_pkg::spr_word_t     spr_b_data_i,
    output logic                        gfx_cs_o,
    output obj_pkg::gfx_req_t           gfx_req_o,
    input  wire                         gfx_ok_i,
    input  wire [31:0]                  gfx_data_i,
    output obj_pkg::obj_pixel_t         obj_pixel_o
);
    import obj_pkg::*;

    logic        line_start;
    logic        scan_done;
    pri_counts_t pri_counts;
    logic        q_we;
    q_addr_t     q_waddr;
    spr_index_t  q_wdata;
    q_addr_t     q_raddr;
    spr_index_t  q_rdata;
    logic        lb_we;
    lbuf_addr_t  lb_addr;
    obj_pixel_t  lb_data;
    logic        render_busy;

    obj_line_scanner i_scanner (
        .CLK96, .RESET96,
        .line_start_i (line_start),
        .vrender_i,
        .scroll_i,
        .spr_a_addr_o,
        .spr_a_data_i,
        .q_we_o       (q_we),
        .q_waddr_o    (q_waddr),
        .q_wdata_o    (q_wdata),
        .scan_done_o  (scan_done),
        .pri_counts_o (pri_counts)
    );

    obj_pri_queue i_queue (
        .CLK96,
        .we_i    (q_we),
        .waddr_i (q_waddr),
        .wdata_i (q_wdata),
        .raddr_i (q_raddr),
        .rdata_o (q_rdata)
    );

    obj_tile_renderer i_renderer (
        .CLK96, .RESET96,
        .scan_done_i  (scan_done),
        .pri_counts_i (pri_counts),
        .vrender_i,
        .scroll_i,
        .q_raddr_o    (q_raddr),
        .q_rdata_i    (q_rdata),
        .spr_b_addr_o,
        .spr_b_data_i,
        .gfx_cs_o,
        .gfx_req_o,
        .gfx_ok_i,
        .gfx_data_i,
        .lb_we_o      (lb_we),
        .lb_addr_o    (lb_addr),
        .lb_data_o    (lb_data),
        .busy_o       (render_busy)
    );

    obj_line_buffer i_line_buffer (
        .CLK96, .RESET96,
        .hblank_i, .vblank_i, .vrender_i,
        .pixel_cen_i, .active_i, .h_i,
        .we_i         (lb_we),
        .addr_i       (lb_addr),
        .data_i       (lb_data),
        .line_start_o (line_start),
        .obj_pixel_o
    );

    // the whole line, scan plus draw, has to fit between two line starts
    a_line_fits: assert property (@(posedge CLK96) disable iff (RESET96)
        line_start |-> !render_busy);

endmodule

`default_nettype wire

// File: bench/obj_bench_models.sv
`timescale 1ns/1ps
`default_nettype none

// sprite RAM with one write port for the testbench and two read ports
module obj_spr_ram_model (
    input  wire                         CLK96,
    input  wire                         we_i,
    input  wire obj_pkg::spr_addr_t     waddr_i,
    input  wire obj_pkg::spr_word_t     wdata_i,
    input  wire obj_pkg::spr_addr_t     a_addr_i,
    output obj_pkg::spr_word_t          a_data_o,
    input  wire obj_pkg::spr_addr_t     b_addr_i,
    output obj_pkg::spr_word_t          b_data_o
);
    import obj_pkg::*;

    spr_word_t mem [8192];

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge CLK96) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        a_data_o <= mem[a_addr_i];  // one cycle latency on both ports
        b_data_o <= mem[b_addr_i];
    end

endmodule

// graphics ROM, answers a held request after 1 to 6 cycles
module obj_gfx_model (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  wire                         cs_i,
    input  wire obj_pkg::gfx_req_t      req_i,
    output logic                        ok_o,
    output logic [31:0]                 data_o
);
    import obj_pkg::*;

    logic       busy;
    logic [2:0] wait_cnt;

    function automatic logic [31:0] slice_data(input logic [2:0] bank,
                                               input logic [14:0] tile,
                                               input logic [15:0] offs);
        logic [31:0] h;
        h = {tile, 1'b0, offs} ^ {bank, 29'd0};
        h = h * 32'h9E3779B1;
        h = h ^ (h >> 15);
        return h;
    endfunction

    always @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            busy     <= 1'b0;
            ok_o     <= 1'b0;
            wait_cnt <= '0;
            data_o   <= '0;
        end else begin
            ok_o <= 1'b0;
            if (ok_o) begin
                busy <= 1'b0;               // cs drops on this edge
            end else if (cs_i && !busy) begin
                busy     <= 1'b1;
                wait_cnt <= 3'($urandom_range(5, 0));
            end else if (busy) begin
                if (wait_cnt == '0) begin
                    ok_o   <= 1'b1;
                    data_o <= slice_data(req_i.bank, req_i.tile_num, req_i.tile_offs);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/obj_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_engine_tb;
    import obj_pkg::*;

    logic        CLK96;
    logic        RESET96;
    logic        hblank;
    logic        vblank;
    logic        pixel_cen;
    logic        active;
    pos_t        vrender;
    pos_t        h;
    obj_scroll_t scroll;
    spr_addr_t   spr_a_addr;
    spr_word_t   spr_a_data;
    spr_addr_t   spr_b_addr;
    spr_word_t   spr_b_data;
    logic        gfx_cs;
    gfx_req_t    gfx_req;
    logic        gfx_ok;
    logic [31:0] gfx_data;
    obj_pixel_t  obj_pixel;
    logic        ram_we;
    spr_addr_t   ram_waddr;
    spr_word_t   ram_wdata;
    logic [1:0]  div;
    logic        chk_on;
    logic        chk_cs;
    logic        rd_prev;
    pos_t        h_prev;
    pos_t        next_v;
    obj_scroll_t scr;
    spr_word_t   spr_tab [1024];
    obj_pixel_t  exp_line [320];

    obj_engine i_obj_engine (
        .CLK96, .RESET96,
        .hblank_i     (hblank),
        .vblank_i     (vblank),
        .pixel_cen_i  (pixel_cen),
        .active_i     (active),
        .vrender_i    (vrender),
        .h_i          (h),
        .scroll_i     (scroll),
        .spr_a_addr_o (spr_a_addr),
        .spr_a_data_i (spr_a_data),
        .spr_b_addr_o (spr_b_addr),
        .spr_b_data_i (spr_b_data),
        .gfx_cs_o     (gfx_cs),
        .gfx_req_o    (gfx_req),
        .gfx_ok_i     (gfx_ok),
        .gfx_data_i   (gfx_data),
        .obj_pixel_o  (obj_pixel)
    );

    obj_spr_ram_model i_spr_ram (
        .CLK96,
        .we_i (ram_we), .waddr_i (ram_waddr), .wdata_i (ram_wdata),
        .a_addr_i (spr_a_addr), .a_data_o (spr_a_data),
        .b_addr_i (spr_b_addr), .b_data_o (spr_b_data)
    );

    obj_gfx_model i_gfx (
        .CLK96, .RESET96,
        .cs_i (gfx_cs), .req_i (gfx_req), .ok_o (gfx_ok), .data_o (gfx_data)
    );

    always #2 CLK96 = ~CLK96;

    // pixel_cen every 4 clocks, 512 pixels per line, hblank from 320
    always @(posedge CLK96) begin
        if (!RESET96) begin
            div       <= div + 1'b1;
            pixel_cen <= (div == 2'd3);
            if (pixel_cen) begin
                h      <= h + 1'b1;
                hblank <= (h + 10'd1 >= 10'd320) && (h != 9'd511);
                active <= (h + 10'd1 < 10'd320) || (h == 9'd511);
                if (h == 9'd511) begin
                    vrender <= vrender + 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] ref_slice(input logic [2:0] bank,
                                              input logic [14:0] tile,
                                              input logic [15:0] offs);
        logic [31:0] x;
        x = {tile, 1'b0, offs} ^ {bank, 29'd0};
        x = x * 32'h9E3779B1;
        x = x ^ (x >> 15);
        return x;
    endfunction

    // expected line from the sprite table, priority 0 first, table order inside
    function automatic void build_expected(input pos_t v);
        int          dy;
        int          x;
        int          xs;
        int          pos;
        spr_word_t   w0;
        spr_word_t   w1;
        spr_word_t   w2;
        spr_word_t   w3;
        logic [15:0] offs;
        logic [31:0] sl;
        logic [3:0]  col;
        for (int i = 0; i < 320; i++) begin
            exp_line[i] = '0;
        end
        for (int p = 0; p < 16; p++) begin
            for (int s = 0; s < 256; s++) begin
                w0 = spr_tab[4*s];
                w1 = spr_tab[4*s+1];
                w2 = spr_tab[4*s+2];
                w3 = spr_tab[4*s+3];
                dy = (int'(v) - int'(w3[15:7]) - int'(scr.scroll_y[8:0])
                     - int'(scr.yoffs[8:0])) & 511;
                if (w0[15] && int'(w0[11:8]) == p && dy < (int'(w3[3:0]) + 1) * 8) begin
                    xs = int'(w2[3:0]);
                    x  = (int'(w2[15:7]) + int'(scr.scroll_x[8:0])
                         + int'(scr.xoffs[8:0])) & 511;
                    for (int c = 0; c <= xs; c++) begin
                        offs = 16'(((dy / 8) * (xs + 1) + c) * 32 + (dy % 8) * 4);
                        sl   = ref_slice({w0[1:0], w1[15]}, w1[14:0], offs);
                        for (int k = 0; k < 8; k++) begin
                            col = sl[4*k +: 4];
                            pos = w0[12] ? x + 8 * (xs - c) + 7 - k : x + 8 * c + k;
                            pos = pos & 511;
                            if (col != 0 && pos < 320) begin
                                exp_line[pos] = {w0[11:8], w0[7:2], col};
                            end
                        end
                    end
                end
            end
        end
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // compare every pixel read out during the checked line
    always @(posedge CLK96) begin
        if (chk_on && rd_prev) begin
            check(32'(obj_pixel), 32'(exp_line[h_prev]), $sformatf("pixel %0d", h_prev));
        end
        if (chk_on && chk_cs) begin
            check(32'(gfx_cs), 32'd0, "gfx_cs after reset");
        end
        rd_prev <= pixel_cen && active;
        h_prev  <= h;
    end

    task automatic wait_new_line();
        pos_t old;
        int   t;
        old = vrender;
        t   = 0;
        @(posedge CLK96);
        while (vrender == old) begin
            t++;
            if (t > 3000) begin
                $display("timeout: no new line began within 3000 clocks");
                $display("Simulation failed");
                $fatal(1);
            end
            @(posedge CLK96);
        end
    endtask

    task automatic sync_line();
        wait_new_line();
        next_v = vrender + 1'b1;
        for (int i = 0; i < 1024; i++) begin
            spr_tab[i] = '0;
        end
        scr = '0;
    endtask

    task automatic set_sprite(input int s, input bit act, input bit flip, input pri_t pri,
                              input logic [5:0] pal, input logic [2:0] bank,
                              input logic [14:0] tile, input pos_t x, input size_t xs,
                              input pos_t y, input size_t ys);
        spr_tab[4*s]   = {act, 2'b00, flip, pri, pal, bank[2:1]};
        spr_tab[4*s+1] = {bank[0], tile};
        spr_tab[4*s+2] = {x, 3'b000, xs};
        spr_tab[4*s+3] = {y, 3'b000, ys};
    endtask

    // load table, draw line next_v, check it while it is read out
    task automatic check_line();
        scroll <= scr;
        for (int i = 0; i < 1024; i++) begin
            ram_we    <= 1'b1;
            ram_waddr <= spr_addr_t'(i);
            ram_wdata <= spr_tab[i];
            @(posedge CLK96);
        end
        ram_we <= 1'b0;
        wait_new_line();
        check(32'(vrender), 32'(next_v), "line after table load");
        build_expected(next_v);
        wait_new_line();
        chk_on <= 1'b1;
        wait_new_line();
        chk_on <= 1'b0;
    endtask

    initial begin
        pos_t        y;
        int          s;
        void'($urandom(73451));
        CLK96     = 0;
        RESET96   = 1;
        hblank    = 0;
        vblank    = 0;
        pixel_cen = 0;
        active    = 1;
        vrender   = '0;
        h         = 9'd300;
        scroll    = '0;
        ram_we    = 0;
        ram_waddr = '0;
        ram_wdata = '0;
        div       = '0;
        chk_on    = 0;
        chk_cs    = 0;
        rd_prev   = 0;
        h_prev    = '0;
        scr       = '0;
        repeat (5) @(posedge CLK96);
        RESET96 <= 1'b0;

        sync_line();                    // empty table straight after reset
        chk_cs <= 1'b1;
        check_line();
        chk_cs <= 1'b0;

        sync_line();                    // one tile, then a line it misses
        set_sprite(5, 1, 0, 4'd3, 6'd10, 3'd2, 15'd100, 9'd40, 4'd0, next_v - 9'd3, 4'd0);
        check_line();
        sync_line();
        set_sprite(5, 1, 0, 4'd3, 6'd10, 3'd2, 15'd100, 9'd40, 4'd0, next_v + 9'd20, 4'd0);
        check_line();

        sync_line();                    // overlap in and across priorities
        set_sprite(1, 1, 0, 4'd5, 6'd1, 3'd0, 15'd7, 9'd100, 4'd1, next_v, 4'd0);
        set_sprite(2, 1, 0, 4'd2, 6'd2, 3'd1, 15'd8, 9'd96, 4'd2, next_v - 9'd4, 4'd1);
        set_sprite(3, 1, 0, 4'd5, 6'd3, 3'd5, 15'd9, 9'd104, 4'd0, next_v - 9'd1, 4'd0);
        check_line();

        for (int f = 0; f < 2; f++) begin   // 3x2 sprite, plain and flipped
            sync_line();
            set_sprite(20, 1, f[0], 4'd7, 6'd33, 3'd6, 15'd4000, 9'd150, 4'd2,
                       next_v - 9'd11, 4'd1);
            check_line();
        end

        sync_line();                    // scroll, clip at 320, inactive sprite
        scr.scroll_x = 13'h1130;
        scr.xoffs    = 13'd8;
        scr.scroll_y = 13'd20;
        scr.yoffs    = 13'd5;
        y = next_v - 9'd27;
        set_sprite(8, 1, 0, 4'd9, 6'd4, 3'd3, 15'd55, 9'd4, 4'd1, y, 4'd0);
        set_sprite(9, 0, 0, 4'd9, 6'd5, 3'd3, 15'd56, 9'd300, 4'd1, y, 4'd0);
        check_line();

        for (int t = 0; t < 50; t++) begin
            sync_line();
            scr = obj_scroll_t'({$urandom, $urandom});
            for (int j = 0; j < 6; j++) begin
                s = $urandom_range(255, 0);
                y = next_v - scr.scroll_y[8:0] - scr.yoffs[8:0] - 9'($urandom_range(40, 0));
                set_sprite(s, $urandom_range(7, 0) != 0, $urandom_range(1, 0) != 0,
                           4'($urandom), 6'($urandom), 3'($urandom), 15'($urandom),
                           9'($urandom), 4'($urandom_range(2, 0)), y,
                           4'($urandom_range(3, 0)));
            end
            check_line();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/obj_pkg.sv
hw/scan/obj_line_scanner.sv
hw/scan/obj_pri_queue.sv
hw/render/obj_tile_renderer.sv
hw/render/obj_line_buffer.sv
hw/obj_engine.sv
bench/obj_bench_models.sv
bench/obj_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the obj_engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module obj_engine_tb \
    -Mdir obj_dir -o obj_engine_sim

./obj_dir/obj_engine_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log
